//--- flist.f
logic/cpu_types_pkg.sv
logic/dcache_pkg.sv
logic/dcache_array_if.sv
logic/dcache_array.sv
logic/dcache_ctrl.sv
logic/dcache.sv
verif/dcache_chk.sv
verif/dcache_tb.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := dcache_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || (echo "FAIL"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import cpu_types_pkg::*; ();

	localparam int NUM_TESTS = 5;
	localparam int MEM_WORDS = 64; // tags 0..3 keep every address below 256
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 400 * 3 / 2;

	logic CLK = 1'b0;
	logic nRST;
	logic dmem_ren, dmem_wen, halt;
	logic mem_wait;
	word_t dmem_addr, dmem_store, mem_load;
	logic dhit, flushed, mem_ren, mem_wen;
	word_t dmem_load, mem_addr, mem_store;

	word_t mem [MEM_WORDS]; // memory behind the cache
	word_t ref_mem [MEM_WORDS]; // every processor write lands here at once
	int wait_cnt;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int test_errors = 0; // errors at the start of the current test

	dcache i_dcache (.*);

	bind dcache dcache_chk i_chk (.*);

	initial begin
		forever #2 CLK = ~CLK; // 4 ns period
	end

	// memory model, random 0..3 wait cycles per transfer
	assign mem_load = mem[mem_addr[7:2]]; // valid in the cycle wait is low
	initial begin
		mem_wait = 1'b0;
		wait_cnt = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = word_t'(i * 4) ^ 32'h5a5a5a5a; // unwritten pattern
		end
		forever begin
			@(posedge CLK);
			if ((mem_ren || mem_wen) && !mem_wait) begin // transfer done at this edge
				if (mem_wen) mem[mem_addr[7:2]] <= mem_store;
				wait_cnt = $urandom_range(3, 0); // delay for the next one
			end else if ((mem_ren || mem_wen) && wait_cnt > 0) begin
				wait_cnt = wait_cnt - 1;
			end
			mem_wait <= (wait_cnt > 0);
		end
	end

	function automatic word_t make_addr(input int tag_n, input int set_n, input int word_n);
		return word_t'((tag_n << 6) | (set_n << 3) | (word_n << 2));
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		assert (act === exp) else begin
			$display("Error: %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// one datapath access, held until dhit
	task automatic access(input logic wr, input word_t addr, input word_t data,
		output int waited);
		waited = 0;
		@(posedge CLK);
		dmem_ren <= !wr;
		dmem_wen <= wr;
		dmem_addr <= addr;
		dmem_store <= data;
		@(negedge CLK);
		while (!dhit) begin
			waited++;
			@(negedge CLK);
		end
		if (wr) begin
			ref_mem[addr[7:2]] = data;
		end else begin
			check_word("dmem_load", ref_mem[addr[7:2]], dmem_load);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		int waited;
		logic wr;
		word_t data;
		void'($urandom(32'hfdbe341f));
		nRST = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		halt = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = word_t'(i * 4) ^ 32'h5a5a5a5a;
		end
		repeat (4) @(posedge CLK);
		nRST <= 1'b1;

		// outputs quiet, first read comes from memory
		@(negedge CLK);
		check_word("mem_ren", '0, word_t'(mem_ren));
		check_word("mem_wen", '0, word_t'(mem_wen));
		check_word("dhit", '0, word_t'(dhit));
		check_word("flushed", '0, word_t'(flushed));
		access(1'b0, make_addr(3, 5, 1), '0, waited);
		finish_test("reset state");

		access(1'b1, make_addr(1, 2, 0), 32'h1234abcd, waited);
		access(1'b0, make_addr(1, 2, 0), '0, waited);
		check_word("read hit wait cycles", '0, word_t'(waited)); // hit in request cycle
		finish_test("hit path");

		// three tags on set 6, two ways, so dirty blocks get evicted
		for (int t = 0; t < 3; t++) begin
			access(1'b1, make_addr(t, 6, t % 2), 32'he0000000 + word_t'(t), waited);
		end
		for (int t = 0; t < 3; t++) begin
			access(1'b0, make_addr(t, 6, 0), '0, waited);
			access(1'b0, make_addr(t, 6, 1), '0, waited);
		end
		finish_test("eviction");

		repeat (200) begin
			wr = 1'(($urandom_range(1, 0)));
			data = $urandom;
			access(wr, make_addr($urandom_range(3, 0), $urandom_range(3, 0),
				$urandom_range(1, 0)), data, waited);
		end
		finish_test("random traffic");

		@(posedge CLK);
		dmem_ren <= 1'b0;
		dmem_wen <= 1'b0;
		halt <= 1'b1;
		@(negedge CLK);
		while (!flushed) @(negedge CLK);
		repeat (10) @(negedge CLK); // checker watches the bus stay quiet
		for (int i = 0; i < MEM_WORDS; i++) begin
			check_word($sformatf("mem[%0d]", i), ref_mem[i], mem[i]);
		end
		finish_test("halt flush");

		$display("tests %0d, checks %0d, errors %0d, checker failures %0d",
			tests_run, checks, errors, i_dcache.i_chk.fails);
		if (errors == 0 && i_dcache.i_chk.fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog, 400 cycles per test with 50 percent margin
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- verif/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk import cpu_types_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic dmem_ren,
	input logic dmem_wen,
	input logic dhit,
	input logic flushed,
	input logic mem_ren,
	input logic mem_wen,
	input logic mem_wait,
	input word_t mem_addr,
	input word_t mem_store
);

	int fails = 0; // failed assertions so far
	logic mem_req;

	assign mem_req = mem_ren || mem_wen;

	// one direction at a time on the memory bus
	a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
	else begin
		fails++;
		$error("mem_ren and mem_wen high in the same cycle");
	end

	// request frozen until memory releases wait
	a_hold: assert property (@(posedge CLK) disable iff (!nRST) (mem_req && mem_wait)
		|=> $stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) && $stable(mem_store))
	else begin
		fails++;
		$error("memory request changed while mem_wait was high");
	end

	a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
	else begin
		fails++;
		$error("flushed dropped after rising");
	end

	// halted cache stays off the bus
	a_quiet: assert property (@(posedge CLK) disable iff (!nRST) flushed |-> !mem_req)
	else begin
		fails++;
		$error("memory request after flushed");
	end

	a_hit_req: assert property (@(posedge CLK) disable iff (!nRST)
		dhit |-> (dmem_ren || dmem_wen))
	else begin
		fails++;
		$error("dhit without a datapath request");
	end

endmodule

//--- logic/dcache.sv
`timescale 1ns/1ps

module dcache import cpu_types_pkg::*; (
	input logic CLK,
	input logic nRST,
	// datapath side
	input logic dmem_ren,
	input logic dmem_wen,
	input word_t dmem_addr,
	input word_t dmem_store,
	input logic halt,
	output word_t dmem_load,
	output logic dhit,
	output logic flushed,
	// memory side, wait style
	input logic mem_wait,
	input word_t mem_load,
	output logic mem_ren,
	output logic mem_wen,
	output word_t mem_addr,
	output word_t mem_store
);

	dcache_array_if arr_if (); // controller to frame storage

	// FSM and memory port
	dcache_ctrl i_ctrl (
		.CLK (CLK),
		.nRST (nRST),
		.dmem_ren (dmem_ren),
		.dmem_wen (dmem_wen),
		.dmem_addr (dmem_addr),
		.dmem_store (dmem_store),
		.halt (halt),
		.mem_wait (mem_wait),
		.mem_load (mem_load),
		.dmem_load (dmem_load),
		.dhit (dhit),
		.flushed (flushed),
		.mem_ren (mem_ren),
		.mem_wen (mem_wen),
		.mem_addr (mem_addr),
		.mem_store (mem_store),
		.arr (arr_if.ctrl)
	);

	// tags, data, valid, dirty, lru
	dcache_array i_array (
		.CLK (CLK),
		.nRST (nRST),
		.arr (arr_if.array)
	);

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import cpu_types_pkg::*, dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic dmem_ren,
	input logic dmem_wen,
	input word_t dmem_addr,
	input word_t dmem_store,
	input logic halt,
	input logic mem_wait,
	input word_t mem_load,
	output word_t dmem_load,
	output logic dhit,
	output logic flushed,
	output logic mem_ren,
	output logic mem_wen,
	output word_t mem_addr,
	output word_t mem_store,
	dcache_array_if.ctrl arr
);

	logic [3:0] state, next_state;
	logic [SCAN_W-1:0] scan_cnt, next_scan_cnt; // frame number, way in bit IDX_W
	addr_t req; // processor address, split
	addr_t maddr; // memory address under construction
	logic req_valid;
	logic scanning;

	assign req = addr_t'(dmem_addr);
	assign req_valid = dmem_ren || dmem_wen;
	assign scanning = (state == ST_SCAN) || (state == ST_FLUSH0) || (state == ST_FLUSH1);

	// array steering
	assign arr.sel_idx = scanning ? scan_cnt[IDX_W-1:0] : req.f.idx;
	assign arr.req_tag = req.f.tag;
	assign arr.req_blkoff = req.f.blkoff;
	assign arr.scan_way = scanning ? scan_cnt[IDX_W] : arr.victim_way;
	assign arr.fill_way = (state == ST_IDLE) ? arr.hit_way : arr.victim_way; // store vs fill
	assign arr.wr_data = (state == ST_IDLE) ? dmem_store : mem_load;

	assign dmem_load = arr.rd_data; // valid with dhit
	assign flushed = (state == ST_HALTED);
	assign mem_addr = maddr.raw;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= ST_IDLE;
			scan_cnt <= '0;
		end else begin
			state <= next_state;
			scan_cnt <= next_scan_cnt;
		end
	end

	always_comb begin
		next_state = state;
		next_scan_cnt = scan_cnt;
		dhit = 1'b0;
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		mem_store = arr.frame_word0;
		arr.wr_word = 1'b0;
		arr.fill_word0 = 1'b0;
		arr.fill_word1 = 1'b0;
		arr.set_tag = 1'b0;
		arr.clr_dirty = 1'b0;
		arr.touch = 1'b0;
		// default address is word 0 of the requested block
		maddr.f.tag = req.f.tag;
		maddr.f.idx = arr.sel_idx;
		maddr.f.blkoff = 1'b0;
		maddr.f.byteoff = 2'b00;
		case (state)
			ST_IDLE: begin
				if (req_valid) begin // pending access served before halt
					if (arr.hit) begin
						dhit = 1'b1;
						arr.touch = 1'b1;
						arr.wr_word = dmem_wen;
					end else if (arr.victim_dirty) begin
						next_state = ST_WB0; // save victim first
					end else begin
						next_state = ST_FILL0;
					end
				end else if (halt) begin
					next_state = ST_SCAN;
				end
			end
			ST_WB0: begin
				mem_wen = 1'b1;
				maddr.f.tag = arr.victim_tag; // victim's own address
				if (!mem_wait) next_state = ST_WB1;
			end
			ST_WB1: begin
				mem_wen = 1'b1;
				maddr.f.tag = arr.victim_tag;
				maddr.f.blkoff = 1'b1;
				mem_store = arr.frame_word1;
				if (!mem_wait) next_state = ST_FILL0;
			end
			ST_FILL0: begin
				mem_ren = 1'b1;
				arr.fill_word0 = !mem_wait; // mem_load valid this cycle
				if (!mem_wait) next_state = ST_FILL1;
			end
			ST_FILL1: begin
				mem_ren = 1'b1;
				maddr.f.blkoff = 1'b1;
				arr.fill_word1 = !mem_wait;
				arr.set_tag = !mem_wait; // block complete
				if (!mem_wait) next_state = ST_IDLE; // retry hits next cycle
			end
			ST_SCAN: begin
				if (scan_cnt == SCAN_W'(FRAMES)) begin
					next_state = ST_HALTED; // all frames seen
				end else if (arr.victim_dirty) begin
					next_state = ST_FLUSH0;
				end else begin
					next_scan_cnt = scan_cnt + 1'b1; // clean or invalid, skip
				end
			end
			ST_FLUSH0: begin
				mem_wen = 1'b1;
				maddr.f.tag = arr.victim_tag;
				if (!mem_wait) next_state = ST_FLUSH1;
			end
			ST_FLUSH1: begin
				mem_wen = 1'b1;
				maddr.f.tag = arr.victim_tag;
				maddr.f.blkoff = 1'b1;
				mem_store = arr.frame_word1;
				if (!mem_wait) begin
					arr.clr_dirty = 1'b1;
					next_scan_cnt = scan_cnt + 1'b1;
					next_state = ST_SCAN;
				end
			end
			ST_HALTED: begin
				next_state = ST_HALTED; // only reset leaves
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

endmodule

//--- logic/dcache_array.sv
`timescale 1ns/1ps

module dcache_array import cpu_types_pkg::*, dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	dcache_array_if.array arr
);

	// frame payload
	logic [TAG_W-1:0] tags [SETS][WAYS];
	word_t data [SETS][WAYS][2]; // two words per block

	// frame state
	logic valid [SETS][WAYS];
	logic dirty [SETS][WAYS];
	logic lru [SETS]; // names the way to evict next

	logic [WAYS-1:0] way_hit;

	// tag compare, both ways in parallel
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = valid[arr.sel_idx][w] && (tags[arr.sel_idx][w] == arr.req_tag);
		end
	end

	assign arr.hit = |way_hit;
	assign arr.hit_way = way_hit[1]; // way 0 unless way 1 matched

	// read word of hitting way
	assign arr.rd_data = data[arr.sel_idx][arr.hit_way][arr.req_blkoff];

	assign arr.victim_way = lru[arr.sel_idx];

	// frame picked by scan_way
	// on a miss that is the LRU victim, during flush the scanned frame
	assign arr.victim_dirty = valid[arr.sel_idx][arr.scan_way]
		&& dirty[arr.sel_idx][arr.scan_way];
	assign arr.victim_tag = tags[arr.sel_idx][arr.scan_way];
	assign arr.frame_word0 = data[arr.sel_idx][arr.scan_way][0];
	assign arr.frame_word1 = data[arr.sel_idx][arr.scan_way][1];

	// valid, dirty, lru
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < SETS; s++) begin
				lru[s] <= 1'b0;
				for (int w = 0; w < WAYS; w++) begin
					valid[s][w] <= 1'b0;
					dirty[s][w] <= 1'b0;
				end
			end
		end else begin
			if (arr.set_tag) begin // block fully filled
				valid[arr.sel_idx][arr.fill_way] <= 1'b1;
				dirty[arr.sel_idx][arr.fill_way] <= 1'b0; // matches memory now
			end
			if (arr.wr_word) begin
				dirty[arr.sel_idx][arr.fill_way] <= 1'b1; // store on hit
			end
			if (arr.clr_dirty) begin
				dirty[arr.sel_idx][arr.scan_way] <= 1'b0; // flushed frame
			end
			if (arr.touch) begin
				lru[arr.sel_idx] <= ~arr.hit_way; // other way goes next
			end
		end
	end

	// tags and data
	always_ff @(posedge CLK) begin
		if (arr.set_tag) begin
			tags[arr.sel_idx][arr.fill_way] <= arr.req_tag;
		end
		if (arr.fill_word0) begin
			data[arr.sel_idx][arr.fill_way][0] <= arr.wr_data;
		end
		if (arr.fill_word1) begin
			data[arr.sel_idx][arr.fill_way][1] <= arr.wr_data;
		end
		if (arr.wr_word) begin
			data[arr.sel_idx][arr.fill_way][arr.req_blkoff] <= arr.wr_data;
		end
	end

endmodule

//--- logic/dcache_array_if.sv
`timescale 1ns/1ps

interface dcache_array_if import cpu_types_pkg::*; ();

	// controller side drives these
	logic [IDX_W-1:0] sel_idx; // set under access or under scan
	logic [TAG_W-1:0] req_tag; // tag of the processor request
	logic req_blkoff; // word of the block for hit read/write
	logic fill_way; // way that takes writes, fills and tag
	logic scan_way; // way whose frame is shown on the victim outputs
	logic wr_word; // processor store on a hit
	word_t wr_data; // store data or fill data
	logic fill_word0; // fill strobes, one per word
	logic fill_word1;
	logic set_tag; // install tag, set valid, clear dirty
	logic clr_dirty; // frame written back during flush
	logic touch; // hit, move LRU away from hit way

	// array side drives these
	logic hit;
	logic hit_way;
	logic victim_way; // LRU choice for the set
	logic victim_dirty; // dirty and valid, frame at scan_way
	logic [TAG_W-1:0] victim_tag;
	word_t frame_word0; // frame at scan_way
	word_t frame_word1;
	word_t rd_data; // hitting way, word at req_blkoff

	modport ctrl (
		output sel_idx, req_tag, req_blkoff, fill_way, scan_way, wr_word, wr_data,
		output fill_word0, fill_word1, set_tag, clr_dirty, touch,
		input hit, hit_way, victim_way, victim_dirty, victim_tag,
		input frame_word0, frame_word1, rd_data
	);

	modport array (
		input sel_idx, req_tag, req_blkoff, fill_way, scan_way, wr_word, wr_data,
		input fill_word0, fill_word1, set_tag, clr_dirty, touch,
		output hit, hit_way, victim_way, victim_dirty, victim_tag,
		output frame_word0, frame_word1, rd_data
	);

endinterface

//--- logic/dcache_pkg.sv
package dcache_pkg;

	// geometry
	localparam int SETS = 8;
	localparam int WAYS = 2;

	// flush walks every frame once, way in the top bit
	localparam int FRAMES = SETS * WAYS; // 16 frames
	localparam int SCAN_W = 5; // counter reaches FRAMES, so one spare bit

	// controller states
	localparam logic [3:0] ST_IDLE = 4'd0; // lookup, hit served here
	localparam logic [3:0] ST_WB0 = 4'd1; // victim word 0 out
	localparam logic [3:0] ST_WB1 = 4'd2; // victim word 1 out
	localparam logic [3:0] ST_FILL0 = 4'd3; // new block word 0 in
	localparam logic [3:0] ST_FILL1 = 4'd4; // new block word 1 in, tag installed
	localparam logic [3:0] ST_SCAN = 4'd5; // halt, one frame checked per cycle
	localparam logic [3:0] ST_FLUSH0 = 4'd6; // dirty frame word 0 out
	localparam logic [3:0] ST_FLUSH1 = 4'd7; // dirty frame word 1 out
	localparam logic [3:0] ST_HALTED = 4'd8; // flushed, stays here

endpackage

//--- logic/cpu_types_pkg.sv
package cpu_types_pkg;

	// address split for the data cache
	localparam int TAG_W = 26; // upper address bits kept per frame
	localparam int IDX_W = 3; // 8 sets

	// one processor word
	typedef logic [31:0] word_t;

	// byte address seen two ways
	// raw is the bus word, f is the cache's split of it
	typedef union packed {
		word_t raw; // whole address as driven on the bus
		struct packed {
			logic [TAG_W-1:0] tag; // compared against both ways
			logic [IDX_W-1:0] idx; // selects the set
			logic blkoff; // word within the two-word block
			logic [1:0] byteoff; // always zero for word access
		} f;
	} addr_t;

endpackage
